/* Makefile */
# Verilator build and run of the dac path testbench

VERILATOR ?= verilator
TOP       ?= tb_dac_path
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Everything OK

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# pass only when the testbench prints the pass line
run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_dac_path.sv */
// ----------------------------------------
// dac path testbench
// bus register checks, pass and sum modes
// ----------------------------------------
`timescale 1ns/1ns

module tb_dac_path;

  localparam int ACK_TIMEOUT = 8;      // cycles to wait for ack

  logic               adc_clk;
  logic               rst_i;
  logic [31:0]        sys_addr_i;
  logic [31:0]        sys_wdata_i;
  logic               sys_wen_i;
  logic               sys_ren_i;
  logic [31:0]        sys_rdata_o;
  logic               sys_ack_o;
  logic               sys_err_o;
  logic signed [13:0] adc_dat_a_i;
  logic signed [13:0] adc_dat_b_i;
  logic signed [13:0] dac_dat_a_o;
  logic signed [13:0] dac_dat_b_o;

  logic [31:0]        lfsr_q;          // random source
  logic               sample_mix;      // favour the 14 bit limits
  logic               model_ready;     // first edge seen
  logic [1:0]         mode_m   [2];    // register model per channel
  logic signed [13:0] offs_m   [2];
  logic [15:0]        satcnt_m [2];
  logic signed [13:0] exp_dac  [2];    // predicted dac after last edge
  logic               exp_ack;         // ack due after last edge
  int                 dac_errors;
  int                 bus_errors;
  int                 timeouts;

  dac_path_top dut_i (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .dac_dat_a_o (dac_dat_a_o),
    .dac_dat_b_o (dac_dat_b_o)
  );

  initial begin
    adc_clk = 1'b0;
    forever #4 adc_clk = ~adc_clk;     // 8 ns period
  end

  // ----------------------------------------
  // random numbers, x^32+x^22+x^2+x+1
  function automatic logic take_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], take_bit()};
    return v;
  endfunction

  function automatic logic signed [13:0] pick_sample();
    logic [31:0]        r;
    logic signed [13:0] v;
    r = rand_bits(2);
    if (sample_mix && r[1:0] == 2'd0)
      v = 14'h1FFF;                    // most positive
    else if (sample_mix && r[1:0] == 2'd1)
      v = 14'h2000;                    // most negative
    else begin
      r = rand_bits(14);
      v = r[13:0];
    end
    return v;
  endfunction

  // expected dac word and clamp flag, {clamp, value}
  function automatic logic [14:0] ref_dac(input logic [1:0] mode,
                                          input logic signed [13:0] offs,
                                          input logic signed [13:0] smp);
    int                 s;
    logic signed [13:0] v;
    logic               clamp;
    v     = '0;
    clamp = 1'b0;
    s     = int'(smp) + int'(offs);
    if (mode == 2'd1)
      v = smp;                         // pass
    else if (mode == 2'd2 && s > 8191) begin
      v     = 14'h1FFF;
      clamp = 1'b1;
    end else if (mode == 2'd2 && s < -8192) begin
      v     = 14'h2000;
      clamp = 1'b1;
    end else if (mode == 2'd2)
      v = s[13:0];
    return {clamp, v};
  endfunction

  function automatic logic [31:0] reg_addr(input logic [9:0] region, input logic [19:0] offs);
    return {2'b00, region, offs};
  endfunction

  // ----------------------------------------
  // bus access, one strobe cycle then ack
  task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int waited;
    @(posedge adc_clk);
    #1;
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(posedge adc_clk);
    #1;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    waited    = 0;
    @(negedge adc_clk);                // ack due in this cycle
    while (!sys_ack_o && waited < ACK_TIMEOUT) begin
      @(negedge adc_clk);
      waited++;
    end
    if (!sys_ack_o) begin
      timeouts++;
      $display("no ack for access to 0x%h within %0d cycles", addr, ACK_TIMEOUT);
    end else if (waited != 0) begin
      bus_errors++;
      $display("ack for access to 0x%h came %0d cycles late", addr, waited);
    end
    rdata = sys_rdata_o;
    err   = sys_err_o;
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp_data,
                            input logic exp_err);
    logic [31:0] data;
    logic        err;
    bus_access(1'b0, addr, 32'h0, data, err);
    if (data !== exp_data) begin
      bus_errors++;
      $display("Error: sys_rdata_o = 0x%h, expected 0x%h, addr 0x%h", data, exp_data, addr);
    end
    if (err !== exp_err) begin
      bus_errors++;
      $display("Error: sys_err_o = 0x%h, expected 0x%h, addr 0x%h", err, exp_err, addr);
    end
  endtask

  task automatic write_check(input logic [31:0] addr, input logic [31:0] data,
                             input logic exp_err);
    logic [31:0] unused;
    logic        err;
    bus_access(1'b1, addr, data, unused, err);
    if (err !== exp_err) begin
      bus_errors++;
      $display("Error: sys_err_o = 0x%h, expected 0x%h, addr 0x%h", err, exp_err, addr);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge adc_clk);
  endtask

  // ----------------------------------------
  // adc samples, new pair every cycle
  always @(posedge adc_clk) begin
    #1;
    adc_dat_a_i = pick_sample();
    adc_dat_b_i = pick_sample();
  end

  // register model, stepped with the dut edge
  always @(posedge adc_clk) begin : model_step
    logic [14:0] r;
    if (rst_i) begin
      for (int ch = 0; ch < 2; ch++) begin
        mode_m[ch]   = 2'd0;
        offs_m[ch]   = '0;
        satcnt_m[ch] = '0;
        exp_dac[ch]  = '0;
      end
      exp_ack = 1'b0;
    end else begin
      exp_ack = sys_wen_i | sys_ren_i;   // every strobe acked next cycle
      for (int ch = 0; ch < 2; ch++) begin
        r = ref_dac(mode_m[ch], offs_m[ch], (ch == 0) ? adc_dat_a_i : adc_dat_b_i);
        exp_dac[ch] = r[13:0];
        if (sys_wen_i && sys_addr_i[29:20] == 10'(ch) && sys_addr_i[19:0] == 20'h8)
          satcnt_m[ch] = '0;           // clear beats count
        else if (r[14])
          satcnt_m[ch] = satcnt_m[ch] + 16'd1;
        if (sys_wen_i && sys_addr_i[29:20] == 10'(ch) && sys_addr_i[19:0] == 20'h0)
          offs_m[ch] = sys_wdata_i[13:0];
        if (sys_wen_i && sys_addr_i[29:20] == 10'(ch) && sys_addr_i[19:0] == 20'h4)
          mode_m[ch] = sys_wdata_i[1:0];
      end
    end
    model_ready = 1'b1;
  end

  // dac outputs and ack checked mid cycle
  always @(negedge adc_clk) begin
    if (model_ready && dac_dat_a_o !== exp_dac[0]) begin
      dac_errors++;
      $display("Error: dac_dat_a_o = 0x%h, expected 0x%h", dac_dat_a_o, exp_dac[0]);
    end
    if (model_ready && dac_dat_b_o !== exp_dac[1]) begin
      dac_errors++;
      $display("Error: dac_dat_b_o = 0x%h, expected 0x%h", dac_dat_b_o, exp_dac[1]);
    end
    if (model_ready && sys_ack_o !== exp_ack) begin
      bus_errors++;
      $display("Error: sys_ack_o = 0x%h, expected 0x%h", sys_ack_o, exp_ack);
    end
  end

  // ----------------------------------------
  // stimulus
  initial begin : stimulus
    logic signed [13:0] offs;
    lfsr_q      = 32'h1860_e45c;
    sample_mix  = 1'b0;
    model_ready = 1'b0;
    rst_i       = 1'b1;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    adc_dat_a_i = '0;
    adc_dat_b_i = '0;
    idle_cycles(16);
    #1 rst_i = 1'b0;

    for (int ch = 0; ch < 2; ch++) begin           // reset values
      read_check(reg_addr(10'(ch), 20'h0), 32'h0, 1'b0);
      read_check(reg_addr(10'(ch), 20'h4), 32'h0, 1'b0);
      read_check(reg_addr(10'(ch), 20'h8), 32'h0, 1'b0);
    end

    read_check(reg_addr(10'h3FF, 20'hF0000), 32'hFFF0_0002, 1'b0);  // config window
    read_check(reg_addr(10'h3FF, 20'hF0004), 32'd8, 1'b0);
    read_check(reg_addr(10'h3FF, 20'hF0008), 32'h0, 1'b0);
    read_check(reg_addr(10'h3FF, 20'h00000), 32'h0, 1'b0);
    write_check(reg_addr(10'h3FF, 20'hF0000), 32'h1234_5678, 1'b0);
    read_check(reg_addr(10'h3FF, 20'hF0000), 32'hFFF0_0002, 1'b0);

    write_check(reg_addr(10'd0, 20'h0), 32'h0000_2ABC, 1'b0);       // sign extension
    read_check(reg_addr(10'd0, 20'h0), 32'hFFFF_EABC, 1'b0);
    write_check(reg_addr(10'd1, 20'h0), 32'hFFFF_0123, 1'b0);
    read_check(reg_addr(10'd1, 20'h0), 32'h0000_0123, 1'b0);
    write_check(reg_addr(10'd0, 20'h4), 32'hFFFF_FFFE, 1'b0);
    read_check(reg_addr(10'd0, 20'h4), 32'h2, 1'b0);
    write_check(reg_addr(10'd1, 20'h4), 32'h3, 1'b0);               // code 3 acts as off
    read_check(reg_addr(10'd1, 20'h4), 32'h3, 1'b0);
    read_check(reg_addr(10'd5, 20'h0), 32'h0, 1'b0);                // unused region
    write_check(reg_addr(10'd5, 20'h4), 32'h0000_DEAD, 1'b0);
    read_check(reg_addr(10'h100, 20'h0), 32'h0, 1'b1);              // unmapped
    write_check(reg_addr(10'h100, 20'h4), 32'h1, 1'b1);

    write_check(reg_addr(10'd0, 20'h4), 32'd1, 1'b0);               // a pass, b off
    write_check(reg_addr(10'd1, 20'h4), 32'd0, 1'b0);
    idle_cycles(200);
    write_check(reg_addr(10'd0, 20'h4), 32'd0, 1'b0);               // a off, b pass
    write_check(reg_addr(10'd1, 20'h4), 32'd1, 1'b0);
    idle_cycles(200);

    sample_mix = 1'b1;
    for (int round = 0; round < 4; round++) begin
      for (int ch = 0; ch < 2; ch++) begin
        offs = pick_sample();
        write_check(reg_addr(10'(ch), 20'h0), {18'h0, offs}, 1'b0);
        write_check(reg_addr(10'(ch), 20'h4), 32'd2, 1'b0);
      end
      idle_cycles(100);
      for (int ch = 0; ch < 2; ch++)                   // pass stops clamping
        write_check(reg_addr(10'(ch), 20'h4), 32'd1, 1'b0);
      for (int ch = 0; ch < 2; ch++)
        read_check(reg_addr(10'(ch), 20'h8), {16'h0, satcnt_m[ch]}, 1'b0);
    end
    for (int ch = 0; ch < 2; ch++) begin
      write_check(reg_addr(10'(ch), 20'h8), 32'hFFFF_FFFF, 1'b0);
      read_check(reg_addr(10'(ch), 20'h8), 32'h0, 1'b0);
    end

    idle_cycles(4);
    $display("errors: dac %0d, bus %0d, timeouts %0d", dac_errors, bus_errors, timeouts);
    if (dac_errors + bus_errors + timeouts == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

/* hdl/bus_response_mux.sv */
// ----------------------------------------
// bus read data multiplexer
// picks channel, config or default reply
// ----------------------------------------
`timescale 1ns/1ns

module bus_response_mux
  import dac_path_pkg::*;
(
  input  resp_sel_t         sel_i,                   // registered by decoder
  region_bus_if.mux         region_i [NUM_CHANNELS],
  output logic [SYS_DW-1:0] sys_rdata_o,
  output logic              sys_ack_o,
  output logic              sys_err_o
);

  logic [SYS_DW-1:0] chan_rdata [NUM_CHANNELS];     // flattened channel replies
  logic              chan_ack   [NUM_CHANNELS];
  logic [SYS_DW-1:0] sysconf_rdata;

  // interface array cannot be indexed at run time
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_flat
    assign chan_rdata[g] = region_i[g].rdata;
    assign chan_ack[g]   = region_i[g].ack;
  end

  // ----------------------------------------
  // static config table, read only
  always_comb begin
    case (sel_i.offset)
      ADDR_SYSCONF_ID:      sysconf_rdata = SYSCONF_ID;
      ADDR_SYSCONF_REGIONS: sysconf_rdata = SYS_DW'(NUM_REGIONS);
      default:              sysconf_rdata = '0;
    endcase
  end

  // ----------------------------------------
  // reply select
  always_comb begin
    sys_rdata_o = '0;
    sys_ack_o   = 1'b0;
    sys_err_o   = 1'b0;
    case (sel_i.kind)
      RESP_CHANNEL: begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
          if (sel_i.region == REGION_W'(i)) begin
            sys_rdata_o = chan_rdata[i];
            sys_ack_o   = chan_ack[i];
          end
        end
      end
      RESP_SYSCONF: begin
        sys_rdata_o = sysconf_rdata;
        sys_ack_o   = 1'b1;                         // writes ignored, still acked
      end
      RESP_UNUSED: begin
        sys_ack_o = 1'b1;                           // empty region, data 0
      end
      RESP_UNMAPPED: begin
        sys_ack_o = 1'b1;                           // keep the master moving
        sys_err_o = 1'b1;
      end
      default: ;                                    // idle, all low
    endcase
    a_err_with_ack : assert (!sys_err_o || sys_ack_o);
  end

endmodule

/* hdl/dac_channel.sv */
// ----------------------------------------
// dac output channel
// offset / mode / clamp counter registers,
// sample + offset sum saturated to 14 bit
// ----------------------------------------
`timescale 1ns/1ns

module dac_channel
  import dac_path_pkg::*;
(
  input  logic          adc_clk,
  input  logic          rst_i,
  input  sample_t       sample_i,   // adc sample, this channel
  region_bus_if.channel bus_s,      // register access
  output sample_t       dac_o       // registered dac word
);

  sample_t             offset_q;    // added in sum mode
  chan_mode_e          mode_q;
  logic [SATCNT_W-1:0] satcnt_q;    // clamped cycles, wraps
  logic [SUM_W-1:0]    sum;         // one guard bit
  sample_t             dac_d;
  logic                clamp;       // sum out of range this cycle

  // ----------------------------------------
  // datapath
  assign sum = {sample_i[SAMPLE_W-1], sample_i} + {offset_q[SAMPLE_W-1], offset_q};

  always_comb begin
    dac_d = '0;
    clamp = 1'b0;
    case (mode_q)
      MODE_PASS: dac_d = sample_i;
      MODE_SUM: begin
        if (sum[SUM_W-1:SUM_W-2] == 2'b01) begin         // pos. overflow
          dac_d = SAT_MAX;
          clamp = 1'b1;
        end else if (sum[SUM_W-1:SUM_W-2] == 2'b10) begin // neg. overflow
          dac_d = SAT_MIN;
          clamp = 1'b1;
        end else begin
          dac_d = sum[SAMPLE_W-1:0];
        end
      end
      default: dac_d = '0;                               // off and code 3
    endcase
  end

  // ----------------------------------------
  // registers and dac output
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      offset_q <= '0;
      mode_q   <= MODE_OFF;
      satcnt_q <= '0;
      dac_o    <= '0;
    end else begin
      dac_o <= dac_d;                                    // one cycle latency
      if (bus_s.wen && bus_s.offset == REG_SATCNT)
        satcnt_q <= '0;                                  // clear wins over count
      else if (clamp)
        satcnt_q <= satcnt_q + 1'b1;
      if (bus_s.wen) begin
        case (bus_s.offset)
          REG_OFFSET: offset_q <= sample_t'(bus_s.wdata[SAMPLE_W-1:0]);
          REG_MODE:   mode_q   <= chan_mode_e'(bus_s.wdata[1:0]);
          default:    ;                                  // satcnt handled above
        endcase
      end
    end
  end

  // bus reply, every strobe acked next cycle
  always_ff @(posedge adc_clk) begin
    if (rst_i)
      bus_s.ack <= 1'b0;
    else
      bus_s.ack <= bus_s.wen | bus_s.ren;
  end

  always_ff @(posedge adc_clk) begin
    if (bus_s.ren) begin
      case (bus_s.offset)
        REG_OFFSET: bus_s.rdata <= {{(SYS_DW-SAMPLE_W){offset_q[SAMPLE_W-1]}}, offset_q};
        REG_MODE:   bus_s.rdata <= {{(SYS_DW-2){1'b0}}, mode_q};
        REG_SATCNT: bus_s.rdata <= {{(SYS_DW-SATCNT_W){1'b0}}, satcnt_q};
        default:    bus_s.rdata <= '0;
      endcase
    end
  end

  // overflow only in sum mode, and only from two operands of one sign
  a_clamp_same_sign : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    clamp |-> (mode_q == MODE_SUM && sample_i[SAMPLE_W-1] == offset_q[SAMPLE_W-1])
  );

  // clamped word keeps the sign of the operands
  a_clamp_sign_kept : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    clamp |=> (dac_o[SAMPLE_W-1] == $past(sample_i[SAMPLE_W-1]))
  );

endmodule

/* hdl/dac_path_pkg.sv */
// ----------------------------------------
// dac path shared definitions
// bus widths, region map, register offsets,
// saturation limits and the bus / mode types
// ----------------------------------------
package dac_path_pkg;

  // ----------------------------------------
  // widths and counts
  localparam int SYS_AW       = 32;       // bus address width
  localparam int SYS_DW       = 32;       // bus data width
  localparam int SAMPLE_W     = 14;       // adc / dac sample width
  localparam int SUM_W        = 15;       // unsaturated sum, one guard bit
  localparam int NUM_REGIONS  = 8;        // regions decoded by the bus
  localparam int NUM_CHANNELS = 2;        // dac channels, regions 0..N-1
  localparam int REGION_W     = 10;       // region index, addr[29:20]
  localparam int OFFS_W       = 20;       // in-region offset, addr[19:0]
  localparam int SATCNT_W     = 16;       // saturation counter width

  // ----------------------------------------
  // saturation limits, 14 bit two's complement
  localparam logic [SAMPLE_W-1:0] SAT_MAX = 14'h1FFF;  // +8191
  localparam logic [SAMPLE_W-1:0] SAT_MIN = 14'h2000;  // -8192

  // ----------------------------------------
  // system configuration window
  localparam logic [REGION_W-1:0] SYSCONF_REGION       = 10'h3FF;
  localparam logic [SYS_DW-1:0]   SYSCONF_ID           = 32'hFFF00002; // class / version
  localparam logic [OFFS_W-1:0]   ADDR_SYSCONF_ID      = 20'hF0000;
  localparam logic [OFFS_W-1:0]   ADDR_SYSCONF_REGIONS = 20'hF0004;

  // channel register map
  localparam logic [OFFS_W-1:0] REG_OFFSET = 20'h00000;  // signed offset
  localparam logic [OFFS_W-1:0] REG_MODE   = 20'h00004;  // channel mode
  localparam logic [OFFS_W-1:0] REG_SATCNT = 20'h00008;  // clamp counter, write clears

  // ----------------------------------------
  // types
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  typedef enum logic [1:0] {
    MODE_OFF  = 2'd0,  // output held at 0
    MODE_PASS = 2'd1,  // adc sample straight through
    MODE_SUM  = 2'd2   // sample + offset, saturated
  } chan_mode_e;       // code 3 acts as off

  typedef enum logic [2:0] {
    RESP_NONE,         // no access last cycle
    RESP_CHANNEL,      // answered by a dac channel
    RESP_SYSCONF,      // constant config window
    RESP_UNUSED,       // decoded region without a block
    RESP_UNMAPPED      // outside the map, ack + err
  } resp_kind_e;

  typedef struct packed {
    resp_kind_e          kind;    // who answers
    logic [REGION_W-1:0] region;  // region index of the access
    logic [OFFS_W-1:0]   offset;  // in-region address
  } resp_sel_t;

endpackage

/* hdl/dac_path_top.sv */
// ----------------------------------------
// dac path top level
// bus decoder, dac channels, reply mux
// ----------------------------------------
`timescale 1ns/1ns

module dac_path_top
  import dac_path_pkg::*;
(
  input  logic              adc_clk,      // sample and bus clock
  input  logic              rst_i,        // sync, active high

  // system bus
  input  logic [SYS_AW-1:0] sys_addr_i,   // address
  input  logic [SYS_DW-1:0] sys_wdata_i,  // write data
  input  logic              sys_wen_i,    // write enable
  input  logic              sys_ren_i,    // read enable
  output logic [SYS_DW-1:0] sys_rdata_o,  // read data
  output logic              sys_ack_o,    // acknowledge
  output logic              sys_err_o,    // bad address

  // analog samples
  input  sample_t           adc_dat_a_i,  // adc ch1
  input  sample_t           adc_dat_b_i,  // adc ch2
  output sample_t           dac_dat_a_o,  // dac ch1
  output sample_t           dac_dat_b_o   // dac ch2
);

  // ----------------------------------------
  // internal wiring
  region_bus_if region_bus [NUM_CHANNELS] ();  // one per channel region

  resp_sel_t sel;                               // decoder -> mux
  sample_t   adc_sample [NUM_CHANNELS];
  sample_t   dac_sample [NUM_CHANNELS];

  // pins to channel index
  assign adc_sample[0] = adc_dat_a_i;
  assign adc_sample[1] = adc_dat_b_i;
  assign dac_dat_a_o   = dac_sample[0];
  assign dac_dat_b_o   = dac_sample[1];

  // ----------------------------------------
  // bus decode
  sys_bus_decoder i_decoder (
    .adc_clk     (adc_clk),
    .rst_i       (rst_i),
    .sys_addr_i  (sys_addr_i),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (sys_wen_i),
    .sys_ren_i   (sys_ren_i),
    .region_o    (region_bus),
    .sel_o       (sel)
  );

  // ----------------------------------------
  // dac channels, region n = channel n
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_chan
    dac_channel i_chan (
      .adc_clk  (adc_clk),
      .rst_i    (rst_i),
      .sample_i (adc_sample[g]),
      .bus_s    (region_bus[g]),
      .dac_o    (dac_sample[g])
    );
  end

  // ----------------------------------------
  // reply to the master
  bus_response_mux i_resp_mux (
    .sel_i       (sel),
    .region_i    (region_bus),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o),
    .sys_err_o   (sys_err_o)
  );

endmodule

/* hdl/region_bus_if.sv */
// ----------------------------------------
// one decoded bus region
// strobes and address out, read reply back
// ----------------------------------------
`timescale 1ns/1ns

interface region_bus_if
  import dac_path_pkg::*;
();

  logic              wen;     // one-cycle write strobe
  logic              ren;     // one-cycle read strobe
  logic [OFFS_W-1:0] offset;  // in-region address
  logic [SYS_DW-1:0] wdata;   // write data
  logic [SYS_DW-1:0] rdata;   // registered read data
  logic              ack;     // registered acknowledge

  // address decoder side
  modport decoder (output wen, ren, offset, wdata);

  // register block side
  modport channel (input wen, ren, offset, wdata, output rdata, ack);

  // read data mux side
  modport mux (input rdata, ack);

endinterface

/* hdl/sys_bus_decoder.sv */
// ----------------------------------------
// system bus region decoder
// strobes regions from addr[29:20] and
// registers which block has to answer
// ----------------------------------------
`timescale 1ns/1ns

module sys_bus_decoder
  import dac_path_pkg::*;
(
  input  logic              adc_clk,
  input  logic              rst_i,
  input  logic [SYS_AW-1:0] sys_addr_i,   // byte address
  input  logic [SYS_DW-1:0] sys_wdata_i,  // write data
  input  logic              sys_wen_i,    // write strobe
  input  logic              sys_ren_i,    // read strobe
  region_bus_if.decoder     region_o [NUM_CHANNELS],
  output resp_sel_t         sel_o         // response select, next cycle
);

  logic [REGION_W-1:0] region_idx;  // addr[29:20]
  logic [OFFS_W-1:0]   region_offs; // addr[19:0]
  logic                access;      // any strobe this cycle
  resp_kind_e          kind_d;

  assign region_idx  = sys_addr_i[29:20];
  assign region_offs = sys_addr_i[19:0];
  assign access      = sys_wen_i | sys_ren_i;

  // ----------------------------------------
  // request side, combinational strobes
  for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_region
    logic hit;                                           // this channel addressed
    assign hit               = (region_idx == REGION_W'(g));
    assign region_o[g].wen    = sys_wen_i & hit;
    assign region_o[g].ren    = sys_ren_i & hit;
    assign region_o[g].offset = region_offs;             // shared by all regions
    assign region_o[g].wdata  = sys_wdata_i;
  end

  // classify the access
  always_comb begin
    if (!access)
      kind_d = RESP_NONE;                                // idle bus
    else if (region_idx < NUM_CHANNELS)
      kind_d = RESP_CHANNEL;
    else if (region_idx < NUM_REGIONS)
      kind_d = RESP_UNUSED;                              // default answer
    else if (region_idx == SYSCONF_REGION)
      kind_d = RESP_SYSCONF;
    else
      kind_d = RESP_UNMAPPED;                            // ack with err
  end

  // ----------------------------------------
  // response side, one cycle later
  always_ff @(posedge adc_clk) begin
    if (rst_i) begin
      sel_o.kind <= RESP_NONE;                           // no stray ack
    end else begin
      sel_o.kind <= kind_d;
    end
    sel_o.region <= region_idx;                          // payload only
    sel_o.offset <= region_offs;
  end

  // master never issues both strobes in one cycle
  a_wen_ren_excl : assert property (
    @(posedge adc_clk) disable iff (rst_i)
    !(sys_wen_i && sys_ren_i)
  );

endmodule

/* sim.f */
hdl/dac_path_pkg.sv
hdl/region_bus_if.sv
hdl/sys_bus_decoder.sv
hdl/dac_channel.sv
hdl/bus_response_mux.sv
hdl/dac_path_top.sv
bench/tb_dac_path.sv
